// ==== all.f ====
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_core.sv
rv_core_asserts.sv
rv_core_checker.sv
rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the rv_core testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module rv_core_tb \
    -o rv_core_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rv_core_sim > sim.log 2>&1 || echo "simulation ended with an error status"
cat sim.log
grep -qx "All tests passed" sim.log && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }

// ==== rv_alu.sv ====
module rv_alu (
    input  rv_pkg::xword_t       a,
    input  rv_pkg::xword_t       b,
    input  rv_pkg::alu_op_e      alu_op,
    input  rv_pkg::branch_kind_e branch_kind,
    output rv_pkg::xword_t       result,
    output logic                 take_branch
);
    localparam int W     = $bits(rv_pkg::xword_t);
    localparam int SHW   = $clog2(W);

    logic [W:0]     diff_full;
    rv_pkg::xword_t diff;
    logic           ovf;
    logic           zero;
    logic           neg;
    logic           negu;
    logic [SHW-1:0] shamt;

    // one subtractor serves sub, slt, sltu and the branches
    // the extra top bit is the unsigned borrow
    assign diff_full = {1'b0, a} - {1'b0, b};
    assign diff      = diff_full[W-1:0];
    assign ovf       = (a[W-1] ^ b[W-1]) & (a[W-1] ^ diff[W-1]);

    assign zero = (diff == '0);
    // signed a < b, sign corrected for overflow
    assign neg  = diff[W-1] ^ ovf;
    // unsigned a < b
    assign negu = diff_full[W];

    // rv64 shifts use six bits of the amount
    assign shamt = b[SHW-1:0];

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = diff;
            rv_pkg::alu_and:  result = a & b;
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_slt:  result = rv_pkg::xword_t'(neg);
            rv_pkg::alu_sltu: result = rv_pkg::xword_t'(negu);
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = rv_pkg::xword_t'($signed(a) >>> shamt);
            default:          result = b;
        endcase
    end

    // branch decision from the flags only
    always_comb begin
        case (branch_kind)
            rv_pkg::br_eq:  take_branch = zero;
            rv_pkg::br_ne:  take_branch = !zero;
            rv_pkg::br_lt:  take_branch = neg;
            rv_pkg::br_ge:  take_branch = !neg;
            rv_pkg::br_ltu: take_branch = negu;
            rv_pkg::br_geu: take_branch = !negu;
            default:        take_branch = 1'b0;
        endcase
    end

endmodule

// ==== rv_core.sv ====
`include "rv_core_config.svh"

module rv_core (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    input  logic            imem_we,
    input  rv_pkg::pc_t     imem_addr,
    input  rv_pkg::instr_t  imem_data,
    output logic            retire,
    output rv_pkg::retire_t retire_info
);
    rv_pkg::pc_t      pc;
    rv_pkg::pc_t      next_pc;
    rv_pkg::pc_t      pc_plus_one;
    rv_pkg::instr_t   instr;
    logic             exec;
    rv_pkg::ctrl_t    ctrl;
    rv_pkg::xword_t   imm;
    rv_pkg::xword_t   imm_words;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::xword_t   rdata1;
    rv_pkg::xword_t   rdata2;
    rv_pkg::xword_t   alu_b;
    rv_pkg::xword_t   alu_result;
    logic             take_branch;
    rv_pkg::xword_t   pc_byte;
    rv_pkg::xword_t   link;
    rv_pkg::xword_t   wb_data;
    logic             rf_we;

    rv_fetch u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .next_pc   (next_pc),
        .pc        (pc),
        .instr     (instr),
        .exec      (exec)
    );

    rv_decode u_decode (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    // x0 destinations count as no write
    // only the exec cycle may commit
    assign rf_we = ctrl.reg_write && (rd != '0) && exec;

    rv_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (rf_we),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign alu_b = ctrl.alu_src ? imm : rdata2;

    rv_alu u_alu (
        .a           (rdata1),
        .b           (alu_b),
        .alu_op      (ctrl.alu_op),
        .branch_kind (ctrl.branch_kind),
        .result      (alu_result),
        .take_branch (take_branch)
    );

    // pc counts words, software sees bytes
    assign pc_plus_one = pc + 1'b1;
    assign pc_byte     = {{(`XLEN-`PC_W-2){1'b0}}, pc, 2'b00};
    assign link        = {{(`XLEN-`PC_W-2){1'b0}}, pc_plus_one, 2'b00};

    // byte offset to word offset, keeping the sign
    assign imm_words = rv_pkg::xword_t'($signed(imm) >>> 2);

    always_comb begin
        if (ctrl.jalr) begin
            next_pc = alu_result[`PC_W+1:2];
        end else if (take_branch || ctrl.jump) begin
            next_pc = pc + imm_words[`PC_W-1:0];
        end else begin
            next_pc = pc_plus_one;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::wb_imm:         wb_data = imm;
            rv_pkg::wb_pc_plus_imm: wb_data = pc_byte + imm;
            rv_pkg::wb_link:        wb_data = link;
            default:                wb_data = alu_result;
        endcase
    end

    // one report per executed word
    assign retire            = exec;
    assign retire_info.pc    = pc;
    assign retire_info.rd    = rd;
    assign retire_info.we    = rf_we;
    assign retire_info.wdata = wb_data;

endmodule

// ==== rv_core_asserts.sv ====
module rv_core_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            run,
    input logic            retire,
    input rv_pkg::retire_t retire_info
);
    // two fetch cycles always separate two retires
    a_retire_gap: assert property (@(posedge clk) disable iff (!rst_n)
        retire |-> !$past(retire) && !$past(retire, 2))
        else $error("retire came less than three cycles after the previous one");

    // with run held the whole time, the next retire is due three cycles on
    a_retire_due: assert property (@(posedge clk) disable iff (!rst_n)
        $past(retire, 3) && $past(run, 2) && $past(run, 1) |-> retire)
        else $error("retire did not come three cycles after the previous one");

    // no instruction executes while reset is held
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !retire)
        else $error("retire was high during reset");

    // x0 is never a write target
    a_x0_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire && retire_info.rd == '0 |-> !retire_info.we)
        else $error("a retire to x0 reported a register write");

endmodule

// ==== rv_core_checker.sv ====
module rv_core_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            retire,
    input  rv_pkg::retire_t retire_info,
    input  int              load_idx,
    input  logic            timed_out,
    input  logic            report,
    output rv_pkg::instr_t  load_word,
    output rv_pkg::pc_t     load_addr,
    output int              rows,
    output logic            done,
    output int              errors
);
    string           t_name [64];
    rv_pkg::instr_t  t_instr [64];
    rv_pkg::retire_t t_exp [64];
    int              n_rows = 0;
    int              pos = 0;
    int              gap = 0;
    logic            seen = 1'b0;
    int              mismatches = 0;
    int              extras = 0;
    int              spacing = 0;

    // small assembler for the formats the core runs
    function automatic rv_pkg::instr_t enc_r(input int f7, input int rs2, input int rs1,
                                             input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_pkg::instr_t enc_i(input int imm, input int rs1, input int f3,
                                             input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic rv_pkg::instr_t enc_u(input int imm, input int rd, input int op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    // branch offset in bytes, bit 0 dropped by the format
    function automatic rv_pkg::instr_t enc_b(input int off, input int rs2, input int rs1,
                                             input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::instr_t enc_j(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // one row per retire, in retire order, pc is the word address
    task automatic add_row(input string name, input rv_pkg::instr_t word, input int pc,
                           input int rd, input logic we, input rv_pkg::xword_t wdata);
        t_name[n_rows]  = name;
        t_instr[n_rows] = word;
        t_exp[n_rows]   = '{pc: rv_pkg::pc_t'(pc), rd: rv_pkg::reg_idx_t'(rd), we: we,
                            wdata: wdata};
        n_rows++;
    endtask

    // x1 = -8 and x2 = 19 feed the arithmetic and the branches
    initial begin
        add_row("addi_neg", enc_i(-8, 0, 0, 1, 'h13), 0, 1, 1'b1, 64'hFFFF_FFFF_FFFF_FFF8);
        add_row("addi_pos", enc_i(19, 0, 0, 2, 'h13), 1, 2, 1'b1, 64'h13);
        add_row("add", enc_r(0, 2, 1, 0, 3), 2, 3, 1'b1, 64'hB);
        add_row("sub", enc_r('h20, 2, 1, 0, 4), 3, 4, 1'b1, 64'hFFFF_FFFF_FFFF_FFE5);
        add_row("and", enc_r(0, 2, 1, 7, 5), 4, 5, 1'b1, 64'h10);
        add_row("or", enc_r(0, 2, 1, 6, 6), 5, 6, 1'b1, 64'hFFFF_FFFF_FFFF_FFFB);
        add_row("xor", enc_r(0, 2, 1, 4, 7), 6, 7, 1'b1, 64'hFFFF_FFFF_FFFF_FFEB);
        add_row("sll", enc_r(0, 2, 1, 1, 8), 7, 8, 1'b1, 64'hFFFF_FFFF_FFC0_0000);
        add_row("srl", enc_r(0, 2, 1, 5, 9), 8, 9, 1'b1, 64'h0000_1FFF_FFFF_FFFF);
        add_row("sra", enc_r('h20, 2, 1, 5, 10), 9, 10, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF);
        add_row("slt", enc_r(0, 2, 1, 2, 11), 10, 11, 1'b1, 64'h1);
        add_row("sltu", enc_r(0, 2, 1, 3, 12), 11, 12, 1'b1, 64'h0);
        add_row("srai", enc_i('h401, 1, 5, 13, 'h13), 12, 13, 1'b1, 64'hFFFF_FFFF_FFFF_FFFC);
        add_row("lui", enc_u('h80001, 14, 'h37), 13, 14, 1'b1, 64'hFFFF_FFFF_8000_1000);
        add_row("auipc", enc_u(1, 15, 'h17), 14, 15, 1'b1, 64'h1038);
        add_row("addi_x0", enc_i(5, 1, 0, 0, 'h13), 15, 0, 1'b0, 64'h0);
        add_row("read_x0", enc_r(0, 2, 0, 0, 16), 16, 16, 1'b1, 64'h13);
        // taken branches skip one word, so the hole after them never retires
        add_row("beq_not", enc_b(8, 2, 1, 0), 17, 0, 1'b0, 64'h0);
        add_row("beq_taken", enc_b(8, 2, 2, 0), 18, 0, 1'b0, 64'h0);
        add_row("bne_not", enc_b(8, 2, 2, 1), 20, 0, 1'b0, 64'h0);
        add_row("bne_taken", enc_b(8, 2, 1, 1), 21, 0, 1'b0, 64'h0);
        add_row("blt_not", enc_b(8, 1, 2, 4), 23, 0, 1'b0, 64'h0);
        add_row("blt_taken", enc_b(8, 2, 1, 4), 24, 0, 1'b0, 64'h0);
        add_row("bge_not", enc_b(8, 2, 1, 5), 26, 0, 1'b0, 64'h0);
        add_row("bge_taken", enc_b(8, 1, 2, 5), 27, 0, 1'b0, 64'h0);
        add_row("bltu_not", enc_b(8, 2, 1, 6), 29, 0, 1'b0, 64'h0);
        add_row("bltu_taken", enc_b(8, 1, 2, 6), 30, 0, 1'b0, 64'h0);
        add_row("bgeu_not", enc_b(8, 1, 2, 7), 32, 0, 1'b0, 64'h0);
        add_row("bgeu_taken", enc_b(8, 2, 1, 7), 33, 0, 1'b0, 64'h0);
        // jal forward, a backward branch, then jalr through the jal link
        add_row("jal", enc_j(20, 17), 35, 17, 1'b1, 64'h90);
        add_row("bne_back", enc_b(-8, 2, 1, 1), 40, 0, 1'b0, 64'h0);
        add_row("jalr", enc_i(24, 17, 0, 18, 'h67), 38, 18, 1'b1, 64'h9C);
        add_row("link_use", enc_i(1, 18, 0, 19, 'h13), 42, 19, 1'b1, 64'h9D);
    end

    assign rows      = n_rows;
    assign load_word = t_instr[load_idx];
    assign load_addr = t_exp[load_idx].pc;
    assign errors    = mismatches + extras + spacing + int'(timed_out);

    task automatic check_field(input string test, input string field,
                               input rv_pkg::xword_t expv, input rv_pkg::xword_t got);
        if (got !== expv) begin
            mismatches++;
            $display("Fail %s %s: expected %h, actual %h", test, field, expv, got);
        end
    endtask

    // rd and wdata only mean something when a write is expected
    task automatic compare_row(input int i);
        rv_pkg::retire_t expv;
        expv = t_exp[i];
        check_field(t_name[i], "pc", rv_pkg::xword_t'(expv.pc), rv_pkg::xword_t'(retire_info.pc));
        check_field(t_name[i], "we", rv_pkg::xword_t'(expv.we), rv_pkg::xword_t'(retire_info.we));
        if (expv.we) begin
            check_field(t_name[i], "rd", rv_pkg::xword_t'(expv.rd),
                        rv_pkg::xword_t'(retire_info.rd));
            check_field(t_name[i], "wdata", expv.wdata, retire_info.wdata);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            pos  = 0;
            gap  = 0;
            seen = 1'b0;
            done <= 1'b0;
        end else begin
            gap++;
            if (retire) begin
                if (seen && gap != 3) begin
                    spacing++;
                    $display("retire came %0d cycles after the previous one, expected 3", gap);
                end
                seen = 1'b1;
                gap  = 0;
                if (pos >= n_rows) begin
                    extras++;
                    $display("retire at pc %h came after the last table row", retire_info.pc);
                end else begin
                    compare_row(pos);
                    pos++;
                    if (pos == n_rows) begin
                        done <= 1'b1;
                    end
                end
            end
        end
    end

    always @(posedge report) begin
        $display("checker: %0d mismatches, %0d extra retires, %0d spacing errors, %0d timeouts",
                 mismatches, extras, spacing, int'(timed_out));
    end

endmodule

// ==== rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// integer register and ALU width
`define XLEN 64

// program counter width, counted in 32-bit words
`define PC_W 15

// instruction memory depth in words
`define IMEM_WORDS 1024

// cycles the instruction memory needs beyond the address cycle
// the fetch FSM is built around exactly two of them
`define IMEM_EXTRA_CYCLES 2

`endif

// ==== rv_core_tb.sv ====
module rv_core_tb;
    localparam int run_limit = 1000;

    logic            clk;
    logic            rst_n;
    logic            run;
    logic            imem_we;
    rv_pkg::pc_t     imem_addr;
    rv_pkg::instr_t  imem_data;
    logic            retire;
    rv_pkg::retire_t retire_info;
    int              load_idx;
    logic            timed_out;
    logic            report;
    rv_pkg::instr_t  load_word;
    rv_pkg::pc_t     load_addr;
    int              rows;
    logic            done;
    int              errors;
    int              waited;

    bind rv_core rv_core_asserts u_asserts (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .retire      (retire),
        .retire_info (retire_info)
    );

    rv_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .retire      (retire),
        .retire_info (retire_info)
    );

    rv_core_checker chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .retire      (retire),
        .retire_info (retire_info),
        .load_idx    (load_idx),
        .timed_out   (timed_out),
        .report      (report),
        .load_word   (load_word),
        .load_addr   (load_addr),
        .rows        (rows),
        .done        (done),
        .errors      (errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        load_idx  = 0;
        timed_out = 1'b0;
        report    = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // program load while halted, the table index runs one cycle ahead of the write
        @(posedge clk);
        load_idx <= 0;
        for (int i = 0; i < rows; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= load_addr;
            imem_data <= load_word;
            load_idx  <= i + 1;
        end
        @(posedge clk);
        imem_we <= 1'b0;
        run     <= 1'b1;

        waited = 0;
        while (!done && waited < run_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!done) begin
            timed_out = 1'b1;
            $display("timeout: the program did not finish within %0d cycles", run_limit);
        end
        // halt, then leave room for a stray retire to be counted
        run <= 1'b0;
        repeat (6) @(posedge clk);

        report = 1'b1;
        @(posedge clk);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== rv_decode.sv ====
module rv_decode (
    input  rv_pkg::instr_t   instr,
    output rv_pkg::ctrl_t    ctrl,
    output rv_pkg::xword_t   imm,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd
);
    // major opcodes handled by this core
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic           alt;
    rv_pkg::xword_t imm_i;
    rv_pkg::xword_t imm_u;
    rv_pkg::xword_t imm_b;
    rv_pkg::xword_t imm_j;

    // funct3 to ALU op, alt picks sub or sra
    function automatic rv_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic sub_ok,
                                                  input logic alt_bit);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (sub_ok && alt_bit) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  op = rv_pkg::alu_sll;
            3'b010:  op = rv_pkg::alu_slt;
            3'b011:  op = rv_pkg::alu_sltu;
            3'b100:  op = rv_pkg::alu_xor;
            3'b101:  op = alt_bit ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  op = rv_pkg::alu_or;
            default: op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    // funct7 bit 5, also bit 10 of the srai immediate
    assign alt    = instr[30];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // sign-extended immediates
    assign imm_i = rv_pkg::xword_t'($signed(instr[31:20]));
    // u already sits at bit 12
    assign imm_u = rv_pkg::xword_t'($signed({instr[31:12], 12'b0}));
    // b and j keep their zero lsb, offset in bytes
    assign imm_b = rv_pkg::xword_t'($signed({instr[31], instr[7], instr[30:25],
                                              instr[11:8], 1'b0}));
    assign imm_j = rv_pkg::xword_t'($signed({instr[31], instr[19:12], instr[20],
                                              instr[30:21], 1'b0}));

    always_comb begin
        case (opcode)
            op_lui, op_auipc: imm = imm_u;
            op_branch:        imm = imm_b;
            op_jal:           imm = imm_j;
            default:          imm = imm_i;
        endcase
    end

    always_comb begin
        // no-op unless an opcode below claims the word
        ctrl.reg_write   = 1'b0;
        ctrl.alu_src     = 1'b0;
        ctrl.alu_op      = rv_pkg::alu_pass_b;
        ctrl.branch_kind = rv_pkg::br_none;
        ctrl.jump        = 1'b0;
        ctrl.jalr        = 1'b0;
        ctrl.wb_sel      = rv_pkg::wb_alu;
        case (opcode)
            op_reg: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op_of(funct3, 1'b1, alt);
            end
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_op_of(funct3, 1'b0, alt);
            end
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_imm;
            end
            op_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_pc_plus_imm;
            end
            op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_link;
            end
            op_jalr: begin
                // target is rs1 plus imm, formed in the ALU
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = rv_pkg::alu_add;
                ctrl.jalr      = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_link;
            end
            op_branch: begin
                ctrl.alu_op = rv_pkg::alu_sub;
                case (funct3)
                    3'b000:  ctrl.branch_kind = rv_pkg::br_eq;
                    3'b001:  ctrl.branch_kind = rv_pkg::br_ne;
                    3'b100:  ctrl.branch_kind = rv_pkg::br_lt;
                    3'b101:  ctrl.branch_kind = rv_pkg::br_ge;
                    3'b110:  ctrl.branch_kind = rv_pkg::br_ltu;
                    3'b111:  ctrl.branch_kind = rv_pkg::br_geu;
                    default: ctrl.branch_kind = rv_pkg::br_none;
                endcase
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

// ==== rv_fetch.sv ====
`include "rv_core_config.svh"

module rv_fetch (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           run,
    input  logic           imem_we,
    input  rv_pkg::pc_t    imem_addr,
    input  rv_pkg::instr_t imem_data,
    input  rv_pkg::pc_t    next_pc,
    output rv_pkg::pc_t    pc,
    output rv_pkg::instr_t instr,
    output logic           exec
);
    // memory index width, the upper pc bits wrap onto the array
    localparam int ADDR_W = $clog2(`IMEM_WORDS);

    rv_pkg::instr_t       mem [`IMEM_WORDS];
    logic [ADDR_W-1:0]    rd_addr_q [`IMEM_EXTRA_CYCLES];
    rv_pkg::fetch_state_e state;
    rv_pkg::fetch_state_e state_nxt;

    // program load port
    // only open while the core is halted
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            mem[imem_addr[ADDR_W-1:0]] <= imem_data;
        end
    end

    // read address delay line, models the slow memory
    // the word for a new pc shows up two edges after the pc moves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `IMEM_EXTRA_CYCLES; i++) begin
                rd_addr_q[i] <= '0;
            end
        end else begin
            rd_addr_q[0] <= pc[ADDR_W-1:0];
            for (int i = 1; i < `IMEM_EXTRA_CYCLES; i++) begin
                rd_addr_q[i] <= rd_addr_q[i-1];
            end
        end
    end

    assign instr = mem[rd_addr_q[`IMEM_EXTRA_CYCLES-1]];

    // wait1 -> wait2 -> exec, then back round
    always_comb begin
        case (state)
            rv_pkg::st_wait1: state_nxt = rv_pkg::st_wait2;
            rv_pkg::st_wait2: state_nxt = rv_pkg::st_exec;
            default:          state_nxt = rv_pkg::st_wait1;
        endcase
    end

    // halted core sits in wait1 at pc 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rv_pkg::st_wait1;
            pc    <= '0;
        end else if (!run) begin
            state <= rv_pkg::st_wait1;
            pc    <= '0;
        end else begin
            state <= state_nxt;
            // pc only moves once the current word has executed
            if (state == rv_pkg::st_exec) begin
                pc <= next_pc;
            end
        end
    end

    assign exec = (state == rv_pkg::st_exec);

endmodule

// ==== rv_pkg.sv ====
`include "rv_core_config.svh"

package rv_pkg;

    // data path value, one register or ALU word
    typedef logic [`XLEN-1:0] xword_t;

    // word address into the instruction memory
    typedef logic [`PC_W-1:0] pc_t;

    // architectural register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // raw 32-bit instruction
    typedef logic [31:0] instr_t;

    // ALU operations
    // pass_b forwards operand b untouched
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // branch condition, resolved from the a minus b flags
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_eq   = 3'd1,
        br_ne   = 3'd2,
        br_lt   = 3'd3,
        br_ge   = 3'd4,
        br_ltu  = 3'd5,
        br_geu  = 3'd6
    } branch_kind_e;

    // write-back source
    // link is the byte address of the following instruction
    typedef enum logic [1:0] {
        wb_alu         = 2'd0,
        wb_imm         = 2'd1,
        wb_pc_plus_imm = 2'd2,
        wb_link        = 2'd3
    } wb_sel_e;

    // fetch stall FSM, one instruction per pass
    typedef enum logic [1:0] {
        st_wait1 = 2'd0,
        st_wait2 = 2'd1,
        st_exec  = 2'd2
    } fetch_state_e;

    // decoded control for one instruction
    typedef struct packed {
        logic         reg_write;
        logic         alu_src;
        alu_op_e      alu_op;
        branch_kind_e branch_kind;
        logic         jump;
        logic         jalr;
        wb_sel_e      wb_sel;
    } ctrl_t;

    // what the core reports for each executed instruction
    typedef struct packed {
        pc_t      pc;
        reg_idx_t rd;
        logic     we;
        xword_t   wdata;
    } retire_t;

endpackage

// ==== rv_regfile.sv ====
`include "rv_core_config.svh"

module rv_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::xword_t   wdata,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    output rv_pkg::xword_t   rdata1,
    output rv_pkg::xword_t   rdata2
);
    rv_pkg::xword_t regs [32];

    // x0 is never written, so its entry stays at the reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= {`XLEN{1'b0}};
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads
    // a write lands at the exec edge, so the next instruction sees it
    assign rdata1 = (raddr1 == '0) ? {`XLEN{1'b0}} : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? {`XLEN{1'b0}} : regs[raddr2];

endmodule
